/* run_sim.sh */
#!/usr/bin/env bash
# build and run the testbench with Verilator, exit 1 when the log reports a failure
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_sw_core -f sw_core.f \
    -o sim_sw_core > sim.log 2>&1 \
    && ./obj_dir/sim_sw_core >> sim.log 2>&1 \
    || echo "TB FAILED" >> sim.log
cat sim.log
grep -q "TB FAILED" sim.log && { echo "simulation failed"; exit 1; } \
    || echo "simulation passed"

/* sw_checker.sv */
`timescale 1ns/1ns

module sw_checker (
    input  logic          clk,
    input  logic          rst,
    input  logic          i_job_valid,
    input  logic          i_job_ready,
    input  sw_pkg::seq_t  i_seq_read,
    input  sw_pkg::seq_t  i_seq_ref,
    input  sw_pkg::len_t  i_read_len,
    input  sw_pkg::len_t  i_ref_len,
    input  logic          i_res_ready,
    input  logic          i_res_valid,
    input  sw_pkg::score_t i_score,
    input  sw_pkg::idx_t  i_row,
    input  sw_pkg::idx_t  i_column,
    output int            o_pass_count,
    output int            o_fail_count
);
    import sw_pkg::*;

    // set by the testbench before each job
    string  test_name = "none";
    int     pass_count = 0;
    int     fail_count = 0;
    logic   pending = 1'b0;
    logic   job_bad = 1'b0;
    logic   holding = 1'b0;
    logic   was_rst = 1'b1;
    int     exp_score;
    int     exp_row;
    int     exp_col;
    score_t held_score;
    idx_t   held_row;
    idx_t   held_col;

    assign o_pass_count = pass_count;
    assign o_fail_count = fail_count;

    function automatic int larger(input int a, input int b);
        return (a > b) ? a : b;
    endfunction

    // Gotoh recurrence walked column by column so the first strict maximum wins
    task automatic run_model(input seq_t rd, input seq_t rf, input int la, input int lb);
        int h [0:SEQ_MAX][0:SEQ_MAX];
        int e [0:SEQ_MAX][0:SEQ_MAX];
        int f [0:SEQ_MAX][0:SEQ_MAX];
        int s;
        for (int i = 0; i <= SEQ_MAX; i++) begin
            for (int j = 0; j <= SEQ_MAX; j++) begin
                h[i][j] = 0;
                e[i][j] = 0;
                f[i][j] = 0;
            end
        end
        exp_score = -1;
        exp_row = 0;
        exp_col = 0;
        for (int j = 1; j <= lb; j++) begin
            for (int i = 1; i <= la; i++) begin
                s = (rd[(i-1)*BASE_W +: BASE_W] == rf[(j-1)*BASE_W +: BASE_W])
                    ? int'(MATCH_SCORE) : int'(MISMATCH_SCORE);
                e[i][j] = larger(larger(h[i][j-1] + int'(GAP_OPEN),
                                        e[i][j-1] + int'(GAP_EXTEND)), 0);
                f[i][j] = larger(larger(h[i-1][j] + int'(GAP_OPEN),
                                        f[i-1][j] + int'(GAP_EXTEND)), 0);
                h[i][j] = larger(larger(0, h[i-1][j-1] + s), larger(e[i][j], f[i][j]));
                if (h[i][j] > exp_score) begin
                    exp_score = h[i][j];
                    exp_row = i - 1;
                    exp_col = j - 1;
                end
            end
        end
    endtask

    task automatic report_test();
        if (job_bad) begin
            $display("test %s failed", test_name);
            fail_count++;
        end else begin
            $display("test %s passed", test_name);
            pass_count++;
        end
        pending = 1'b0;
    endtask

    task automatic check_result();
        if (!pending) begin
            $display("%s: result handshake without an accepted job", test_name);
            job_bad = 1'b1;
        end else if (int'(i_score) != exp_score || int'(i_row) != exp_row
                     || int'(i_column) != exp_col) begin
            $display("Mismatch %s: expected %0d row %0d col %0d, actual %0d row %0d col %0d",
                     test_name, exp_score, exp_row, exp_col,
                     int'(i_score), int'(i_row), int'(i_column));
            job_bad = 1'b1;
        end
        report_test();
    endtask

    always @(posedge clk) begin
        if (was_rst && !rst) begin
            if (!i_job_ready || i_res_valid) begin
                $display("test reset_state failed: o_ready low or o_valid high after reset");
                fail_count++;
            end else begin
                $display("test reset_state passed");
                pass_count++;
            end
        end
        was_rst = rst;
        if (!rst) begin
            if (i_job_valid && i_job_ready) begin
                run_model(i_seq_read, i_seq_ref, int'(i_read_len), int'(i_ref_len));
                pending = 1'b1;
                job_bad = 1'b0;
            end
            if (i_res_valid) begin
                if (i_job_ready) begin
                    $display("%s: o_ready is high while a result waits", test_name);
                    job_bad = 1'b1;
                end
                if (holding && (i_score !== held_score || i_row !== held_row
                                || i_column !== held_col)) begin
                    $display("%s: result changed while o_valid was held", test_name);
                    job_bad = 1'b1;
                end
                held_score = i_score;
                held_row = i_row;
                held_col = i_column;
                holding = 1'b1;
                if (i_res_ready) begin
                    check_result();
                    holding = 1'b0;
                end
            end else if (holding) begin
                $display("%s: o_valid dropped before the handshake", test_name);
                job_bad = 1'b1;
                report_test();
                holding = 1'b0;
            end
        end
    end

endmodule

/* sw_core.f */
sw_pkg.sv
sw_feed_if.sv
sw_ctrl.sv
sw_pe.sv
sw_pe_array.sv
sw_max_tracker.sv
sw_core.sv
sw_checker.sv
tb_sw_core.sv

/* sw_core.sv */
`timescale 1ns/1ns

module sw_core (
    input  logic            clk,
    input  logic            rst,
    input  logic            i_valid,
    output logic            o_ready,
    input  sw_pkg::seq_t    i_seq_read,
    input  sw_pkg::seq_t    i_seq_ref,
    input  sw_pkg::len_t    i_read_len,
    input  sw_pkg::len_t    i_ref_len,
    input  logic            i_ready,
    output logic            o_valid,
    output sw_pkg::score_t  o_score,
    output sw_pkg::idx_t    o_row,
    output sw_pkg::idx_t    o_column
);
    import sw_pkg::*;

    logic                 clear;
    logic                 scan_start;
    logic                 scan_done;
    logic [SEQ_MAX-1:0]   cell_valid;
    score_t [SEQ_MAX-1:0] cell_score;
    idx_t [SEQ_MAX-1:0]   cell_row;

    sw_feed_if feed_bus ();

    sw_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .i_valid      (i_valid),
        .o_ready      (o_ready),
        .i_seq_read   (i_seq_read),
        .i_seq_ref    (i_seq_ref),
        .i_read_len   (i_read_len),
        .i_ref_len    (i_ref_len),
        .i_ready      (i_ready),
        .o_valid      (o_valid),
        .feed         (feed_bus),
        .o_clear      (clear),
        .o_scan_start (scan_start),
        .i_scan_done  (scan_done)
    );

    sw_pe_array u_array (
        .clk          (clk),
        .rst          (rst),
        .feed         (feed_bus),
        .o_cell_valid (cell_valid),
        .o_cell_score (cell_score),
        .o_cell_row   (cell_row)
    );

    sw_max_tracker u_tracker (
        .clk          (clk),
        .rst          (rst),
        .i_clear      (clear),
        .i_cell_valid (cell_valid),
        .i_cell_score (cell_score),
        .i_cell_row   (cell_row),
        .i_ref_len    (feed_bus.ref_len),
        .i_scan_start (scan_start),
        .o_scan_done  (scan_done),
        .o_score      (o_score),
        .o_row        (o_row),
        .o_column     (o_column)
    );

endmodule

/* sw_ctrl.sv */
`timescale 1ns/1ns

module sw_ctrl (
    input  logic           clk,
    input  logic           rst,
    input  logic           i_valid,
    output logic           o_ready,
    input  sw_pkg::seq_t   i_seq_read,
    input  sw_pkg::seq_t   i_seq_ref,
    input  sw_pkg::len_t   i_read_len,
    input  sw_pkg::len_t   i_ref_len,
    input  logic           i_ready,
    output logic           o_valid,
    sw_feed_if.ctrl        feed,
    output logic           o_clear,
    output logic           o_scan_start,
    input  logic           i_scan_done
);
    import sw_pkg::*;

    sw_state_t state;
    sw_state_t state_n;
    cnt_t      cnt;
    cnt_t      calc_last;
    logic      accept;
    logic      clear;
    seq_t      read_sr;
    seq_t      ref_seq;
    len_t      read_len;
    len_t      ref_len;

    assign o_ready = (state == IDLE);
    assign o_valid = (state == DONE);
    assign accept = i_valid && o_ready;
    assign clear = (state == LOAD);
    assign o_clear = clear;
    assign o_scan_start = (state == DRAIN) && (cnt == cnt_t'(DRAIN_CYCLES - 1));

    // last wavefront cycle is La + Lb - 2
    assign calc_last = cnt_t'(read_len) + cnt_t'(ref_len) - cnt_t'(2);

    always_comb begin
        state_n = state;
        case (state)
            IDLE:    if (accept) state_n = LOAD;
            LOAD:    state_n = CALC;
            CALC:    if (cnt == calc_last) state_n = DRAIN;
            DRAIN:   if (o_scan_start) state_n = SCAN;
            SCAN:    if (i_scan_done) state_n = DONE;
            DONE:    if (i_ready) state_n = IDLE;
            default: state_n = IDLE;
        endcase
    end

    // counter restarts on every state change
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
            cnt <= '0;
        end else begin
            state <= state_n;
            cnt <= (state_n != state) ? '0 : cnt + 1'b1;
        end
    end

    // job capture, then one read base per CALC cycle
    always_ff @(posedge clk) begin
        if (accept) begin
            read_sr <= i_seq_read;
            ref_seq <= i_seq_ref;
            read_len <= i_read_len;
            ref_len <= i_ref_len;
        end else if (state == CALC) begin
            read_sr <= read_sr >> BASE_W;
        end
    end

    assign feed.feed_valid = (state == CALC) && (cnt < cnt_t'(read_len));
    assign feed.feed_base = read_sr[BASE_W-1:0];
    assign feed.feed_row = idx_t'(cnt);
    assign feed.ref_seq = ref_seq;
    assign feed.ref_len = ref_len;
    assign feed.clear = clear;

    a_len_range: assert property (@(posedge clk) disable iff (rst)
        accept |-> (i_read_len != '0) && (i_read_len <= len_t'(SEQ_MAX))
                && (i_ref_len != '0) && (i_ref_len <= len_t'(SEQ_MAX)));

endmodule

/* sw_feed_if.sv */
`timescale 1ns/1ns

interface sw_feed_if;
    import sw_pkg::*;

    // read base stream into PE 0
    logic   feed_valid;
    base_t  feed_base;
    idx_t   feed_row;

    // reference held for the whole job
    seq_t   ref_seq;
    len_t   ref_len;

    // zeroes the array before a new job
    logic   clear;

    modport ctrl (
        output feed_valid, feed_base, feed_row, ref_seq, ref_len, clear
    );

    modport array (
        input feed_valid, feed_base, feed_row, ref_seq, ref_len, clear
    );

endinterface

/* sw_max_tracker.sv */
`timescale 1ns/1ns

module sw_max_tracker (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  i_clear,
    input  logic [sw_pkg::SEQ_MAX-1:0]            i_cell_valid,
    input  sw_pkg::score_t [sw_pkg::SEQ_MAX-1:0]  i_cell_score,
    input  sw_pkg::idx_t [sw_pkg::SEQ_MAX-1:0]    i_cell_row,
    input  sw_pkg::len_t                          i_ref_len,
    input  logic                                  i_scan_start,
    output logic                                  o_scan_done,
    output sw_pkg::score_t                        o_score,
    output sw_pkg::idx_t                          o_row,
    output sw_pkg::idx_t                          o_column
);
    import sw_pkg::*;

    score_t best [SEQ_MAX];
    idx_t   best_row [SEQ_MAX];
    logic   scanning;
    idx_t   scan_idx;
    score_t scan_score;
    idx_t   scan_row;

    // rows arrive in order so a strict compare keeps the lowest row on ties
    always_ff @(posedge clk) begin
        for (int j = 0; j < SEQ_MAX; j++) begin
            if (i_clear) begin
                best[j] <= SCORE_INIT;
                best_row[j] <= '0;
            end else if (i_cell_valid[j] && (i_cell_score[j] > best[j])) begin
                best[j] <= i_cell_score[j];
                best_row[j] <= i_cell_row[j];
            end
        end
    end

    assign scan_score = best[scan_idx];
    assign scan_row = best_row[scan_idx];

    // last column of the reference ends the scan
    assign o_scan_done = scanning && (len_t'(scan_idx) + len_t'(1) == i_ref_len);

    // one PE per cycle from column 0 and the first strict maximum wins
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            scanning <= 1'b0;
            scan_idx <= '0;
            o_score <= SCORE_INIT;
            o_row <= '0;
            o_column <= '0;
        end else if (i_scan_start) begin
            scanning <= 1'b1;
            scan_idx <= '0;
            o_score <= SCORE_INIT;
            o_row <= '0;
            o_column <= '0;
        end else if (scanning) begin
            if (scan_score > o_score) begin
                o_score <= scan_score;
                o_row <= scan_row;
                o_column <= scan_idx;
            end
            scan_idx <= scan_idx + 1'b1;
            if (o_scan_done) begin
                scanning <= 1'b0;
            end
        end
    end

    // every active column produced at least one cell
    a_result_found: assert property (@(posedge clk) disable iff (rst)
        o_scan_done |=> !o_score[SCORE_W-1]);

endmodule

/* sw_pe.sv */
`timescale 1ns/1ns

module sw_pe (
    input  logic            clk,
    input  logic            rst,
    input  logic            i_clear,
    input  logic            i_base_valid,
    input  sw_pkg::base_t   i_base,
    input  sw_pkg::idx_t    i_row,
    input  sw_pkg::base_t   i_ref_base,
    input  logic            i_ref_active,
    input  sw_pkg::score_t  i_top_h,
    input  sw_pkg::score_t  i_top_e,
    input  sw_pkg::score_t  i_left_h,
    input  sw_pkg::score_t  i_left_f,
    input  sw_pkg::score_t  i_diag_h,
    output sw_pkg::score_t  o_h,
    output sw_pkg::score_t  o_e,
    output sw_pkg::score_t  o_f,
    output sw_pkg::score_t  o_h_dly,
    output logic            o_base_valid,
    output sw_pkg::base_t   o_base,
    output sw_pkg::idx_t    o_row
);
    import sw_pkg::*;

    score_t e_new;
    score_t f_new;
    score_t diag;
    score_t h_new;
    logic   cell_en;

    function automatic score_t max_s(input score_t a, input score_t b);
        return (a > b) ? a : b;
    endfunction

    assign cell_en = i_base_valid && i_ref_active;

    always_comb begin
        // gap along the reference, from the previous column
        e_new = max_s(max_s(i_top_h + GAP_OPEN, i_top_e + GAP_EXTEND), '0);
        // gap along the read, from the previous row
        f_new = max_s(max_s(i_left_h + GAP_OPEN, i_left_f + GAP_EXTEND), '0);
        diag = i_diag_h + ((i_base == i_ref_base) ? MATCH_SCORE : MISMATCH_SCORE);
        h_new = max_s(max_s(diag, '0), max_s(e_new, f_new));
    end

    // h_dly shifts only with a real cell, so it is H of the previous row
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_h <= '0;
            o_e <= '0;
            o_f <= '0;
            o_h_dly <= '0;
        end else if (i_clear) begin
            o_h <= '0;
            o_e <= '0;
            o_f <= '0;
            o_h_dly <= '0;
        end else if (cell_en) begin
            o_h_dly <= o_h;
            o_h <= h_new;
            o_e <= e_new;
            o_f <= f_new;
        end
    end

    // read base moves one PE per cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_base_valid <= 1'b0;
        end else if (i_clear) begin
            o_base_valid <= 1'b0;
        end else begin
            o_base_valid <= i_base_valid;
        end
    end

    always_ff @(posedge clk) begin
        o_base <= i_base;
        o_row <= i_row;
    end

    // a cell is never negative and gains at most one per read base
    a_h_range: assert property (@(posedge clk) disable iff (rst)
        (cell_en && !i_clear) |=> !o_h[SCORE_W-1] && (o_h <= score_t'(o_row) + score_t'(1)));

endmodule

/* sw_pe_array.sv */
`timescale 1ns/1ns

module sw_pe_array (
    input  logic                                  clk,
    input  logic                                  rst,
    sw_feed_if.array                              feed,
    output logic [sw_pkg::SEQ_MAX-1:0]            o_cell_valid,
    output sw_pkg::score_t [sw_pkg::SEQ_MAX-1:0]  o_cell_score,
    output sw_pkg::idx_t [sw_pkg::SEQ_MAX-1:0]    o_cell_row
);
    import sw_pkg::*;

    // per-PE outputs
    score_t pe_h [SEQ_MAX];
    score_t pe_e [SEQ_MAX];
    score_t pe_f [SEQ_MAX];
    score_t pe_h_dly [SEQ_MAX];
    logic   pe_valid [SEQ_MAX];
    base_t  pe_base [SEQ_MAX];
    idx_t   pe_row [SEQ_MAX];

    // per-PE inputs from the neighbour upstream
    logic   in_valid [SEQ_MAX];
    base_t  in_base [SEQ_MAX];
    idx_t   in_row [SEQ_MAX];
    score_t top_h [SEQ_MAX];
    score_t top_e [SEQ_MAX];
    score_t diag_h [SEQ_MAX];
    logic   active [SEQ_MAX];

    for (genvar j = 0; j < SEQ_MAX; j++) begin : g_pe
        if (j == 0) begin : g_head
            // first column sees the feed and a zero border
            assign in_valid[j] = feed.feed_valid;
            assign in_base[j] = feed.feed_base;
            assign in_row[j] = feed.feed_row;
            assign top_h[j] = '0;
            assign top_e[j] = '0;
            assign diag_h[j] = '0;
        end else begin : g_link
            assign in_valid[j] = pe_valid[j-1];
            assign in_base[j] = pe_base[j-1];
            assign in_row[j] = pe_row[j-1];
            assign top_h[j] = pe_h[j-1];
            assign top_e[j] = pe_e[j-1];
            assign diag_h[j] = pe_h_dly[j-1];
        end

        // columns past the reference end stay out of the result
        assign active[j] = len_t'(j) < feed.ref_len;

        sw_pe u_pe (
            .clk          (clk),
            .rst          (rst),
            .i_clear      (feed.clear),
            .i_base_valid (in_valid[j]),
            .i_base       (in_base[j]),
            .i_row        (in_row[j]),
            .i_ref_base   (feed.ref_seq[j*BASE_W +: BASE_W]),
            .i_ref_active (active[j]),
            .i_top_h      (top_h[j]),
            .i_top_e      (top_e[j]),
            .i_left_h     (pe_h[j]),
            .i_left_f     (pe_f[j]),
            .i_diag_h     (diag_h[j]),
            .o_h          (pe_h[j]),
            .o_e          (pe_e[j]),
            .o_f          (pe_f[j]),
            .o_h_dly      (pe_h_dly[j]),
            .o_base_valid (pe_valid[j]),
            .o_base       (pe_base[j]),
            .o_row        (pe_row[j])
        );

        assign o_cell_valid[j] = pe_valid[j] && active[j];
        assign o_cell_score[j] = pe_h[j];
        assign o_cell_row[j] = pe_row[j];
    end

endmodule

/* sw_pkg.sv */
package sw_pkg;

    // array size and field widths
    localparam int SEQ_MAX = 16;
    localparam int BASE_W = 2;
    localparam int SCORE_W = 10;
    localparam int IDX_W = $clog2(SEQ_MAX);
    localparam int LEN_W = IDX_W + 1;
    localparam int CNT_W = IDX_W + 2;

    // cycles between the last fed base and the start of the scan
    localparam int DRAIN_CYCLES = 2;

    typedef logic [BASE_W-1:0] base_t;

    // base k sits in bits [2k+1:2k]
    typedef logic [SEQ_MAX*BASE_W-1:0] seq_t;

    // length from 1 to SEQ_MAX
    typedef logic [LEN_W-1:0] len_t;
    typedef logic [IDX_W-1:0] idx_t;
    typedef logic signed [SCORE_W-1:0] score_t;
    typedef logic [CNT_W-1:0] cnt_t;

    // gap open already includes the first gap base
    localparam score_t MATCH_SCORE = score_t'(1);
    localparam score_t MISMATCH_SCORE = score_t'(-4);
    localparam score_t GAP_OPEN = score_t'(-6);
    localparam score_t GAP_EXTEND = score_t'(-1);

    // below any real cell score
    localparam score_t SCORE_INIT = score_t'(-1);

    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        CALC,
        DRAIN,
        SCAN,
        DONE
    } sw_state_t;

endpackage

/* tb_sw_core.sv */
`timescale 1ns/1ns

module tb_sw_core;
    import sw_pkg::*;

    localparam int WAIT_LIMIT = 500;

    logic   clk;
    logic   rst;
    logic   i_valid;
    logic   o_ready;
    seq_t   i_seq_read;
    seq_t   i_seq_ref;
    len_t   i_read_len;
    len_t   i_ref_len;
    logic   i_ready;
    logic   o_valid;
    score_t o_score;
    idx_t   o_row;
    idx_t   o_column;
    int     pass_count;
    int     fail_count;
    logic   timed_out;
    seq_t   same_seq;

    sw_core u_dut (
        .clk        (clk),
        .rst        (rst),
        .i_valid    (i_valid),
        .o_ready    (o_ready),
        .i_seq_read (i_seq_read),
        .i_seq_ref  (i_seq_ref),
        .i_read_len (i_read_len),
        .i_ref_len  (i_ref_len),
        .i_ready    (i_ready),
        .o_valid    (o_valid),
        .o_score    (o_score),
        .o_row      (o_row),
        .o_column   (o_column)
    );

    sw_checker u_check (
        .clk          (clk),
        .rst          (rst),
        .i_job_valid  (i_valid),
        .i_job_ready  (o_ready),
        .i_seq_read   (i_seq_read),
        .i_seq_ref    (i_seq_ref),
        .i_read_len   (i_read_len),
        .i_ref_len    (i_ref_len),
        .i_res_ready  (i_ready),
        .i_res_valid  (o_valid),
        .i_score      (o_score),
        .i_row        (o_row),
        .i_column     (o_column),
        .o_pass_count (pass_count),
        .o_fail_count (fail_count)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // move to just after the next rising edge
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        while (!o_ready && n < WAIT_LIMIT) begin
            step();
            n++;
        end
        if (!o_ready) begin
            $display("timeout: o_ready stayed low for %0d cycles", WAIT_LIMIT);
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_valid();
        int n;
        n = 0;
        while (!o_valid && n < WAIT_LIMIT) begin
            step();
            n++;
        end
        if (!o_valid) begin
            $display("timeout: o_valid stayed low for %0d cycles", WAIT_LIMIT);
            timed_out = 1'b1;
        end
    endtask

    // one job with i_ready held low for hold cycles before the handshake
    task automatic run_job(input string name, input seq_t rd, input seq_t rf,
                           input int la, input int lb, input int hold);
        if (!timed_out) begin
            wait_ready();
        end
        if (!timed_out) begin
            u_check.test_name = name;
            i_valid = 1'b1;
            i_seq_read = rd;
            i_seq_ref = rf;
            i_read_len = len_t'(la);
            i_ref_len = len_t'(lb);
            step();
            i_valid = 1'b0;
            wait_valid();
        end
        if (!timed_out) begin
            repeat (hold) step();
            i_ready = 1'b1;
            step();
            i_ready = 1'b0;
        end
    endtask

    initial begin
        void'($urandom(58672));
        timed_out = 1'b0;
        rst = 1'b1;
        i_valid = 1'b0;
        i_seq_read = '0;
        i_seq_ref = '0;
        i_read_len = len_t'(1);
        i_ref_len = len_t'(1);
        i_ready = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        for (int k = 0; k < 40; k++) begin
            run_job($sformatf("random_%0d", k), $urandom, $urandom,
                    $urandom_range(1, 16), $urandom_range(1, 16), $urandom_range(0, 3));
        end
        for (int len = 1; len <= 16; len += 5) begin
            same_seq = $urandom;
            run_job($sformatf("identical_%0d", len), same_seq, same_seq, len, len, 0);
        end
        run_job("mismatch_all", '0, {SEQ_MAX{2'b01}}, 16, 16, 1);
        run_job("mismatch_short", '0, {SEQ_MAX{2'b01}}, 3, 7, 0);
        run_job("len1_both", $urandom, $urandom, 1, 1, 0);
        run_job("len1_read", $urandom, $urandom, 1, $urandom_range(2, 16), 0);
        run_job("len1_ref", $urandom, $urandom, $urandom_range(2, 16), 1, 0);
        for (int k = 0; k < 4; k++) begin
            run_job($sformatf("backpressure_%0d", k), $urandom, $urandom,
                    $urandom_range(1, 16), $urandom_range(1, 16), $urandom_range(5, 20));
        end
        // back to back jobs without idle cycles
        run_job("short_ref", $urandom, $urandom, 16, 2, 0);
        run_job("short_read", $urandom, $urandom, 2, 16, 0);
        run_job("single_ref", $urandom, $urandom, 16, 1, 0);
        run_job("single_read", $urandom, $urandom, 1, 16, 0);

        $display("tests passed %0d failed %0d", pass_count, fail_count);
        if (timed_out || fail_count != 0 || pass_count == 0) begin
            $display("TB FAILED");
        end else begin
            $display("TB PASSED");
        end
        $finish;
    end

endmodule
